// ==== bench/flash_model.sv ====
/*
 * behavioral parallel nor flash for the testbench
 * asynchronous read, data is the low address bits xor a fixed pattern
 */

`timescale 1ns/1ps

module flash_model (
  input  flash_pkg::flash_addr_t flash_addr_i,
  input  logic                   flash_ce_i,
  input  logic                   flash_we_n_i,
  output flash_pkg::wb_data_t    flash_data_o
);

  // pattern mixed into every read word
  localparam logic [15:0] DATA_XOR = 16'h5a5a;

  // data only while selected and in read mode
  always_comb begin
    if (flash_ce_i && flash_we_n_i) begin
      flash_data_o = flash_addr_i[15:0] ^ DATA_XOR;
    end else begin
      // quiet bus between accesses
      flash_data_o = 16'h0000;
    end
  end

endmodule

// ==== bench/tb_flash_subsys.sv ====
/*
 * testbench for the dual-port flash read subsystem
 * stimulus table, shadow page bases and round-robin pointer,
 * error counters and a cycle watchdog
 */

`timescale 1ns/1ps

`include "flash_defs.svh"

module tb_flash_subsys;

  localparam int RW         = `FLASH_READ_WAIT;
  // per-row cycle budget, also the ack wait limit
  localparam int ROW_CYCLES = 2 * RW + 6;
  localparam int OP_READ    = 0;
  localparam int OP_BASE    = 1;
  localparam int OP_PLAIN   = 2;
  localparam bit PA         = 1'b0;
  localparam bit PB         = 1'b1;

  logic                     wb_clk_i;
  logic                     reset_i;
  logic [15:0]              wba_dat_i;
  logic [15:0]              wba_dat_o;
  logic [15:0]              wba_adr_i;
  logic                     wba_we_i;
  logic                     wba_tga_i;
  logic                     wba_stb_i;
  logic                     wba_cyc_i;
  logic                     wba_ack_o;
  logic [15:0]              wbb_dat_i;
  logic [15:0]              wbb_dat_o;
  logic [15:0]              wbb_adr_i;
  logic                     wbb_we_i;
  logic                     wbb_tga_i;
  logic                     wbb_stb_i;
  logic                     wbb_cyc_i;
  logic                     wbb_ack_o;
  logic [`FLASH_ADDR_W-1:0] flash_addr_o;
  logic [15:0]              flash_data;
  logic                     flash_we_n_o;
  logic                     flash_ce_o;

  // stimulus table, one row per bus cycle
  string       t_name[$];
  bit          t_port[$];
  int          t_op[$];
  bit          t_tga[$];
  logic [15:0] t_adr[$];
  logic [15:0] t_wdat[$];
  bit          t_both[$];

  // testbench view of page bases and last granted port
  logic [`FLASH_BASE_W-1:0] base_sh [2];
  bit                       last_b_sh;

  // per-port results of a tied pair
  bit                       pair_done [2];
  int                       pair_cyc  [2];
  logic [15:0]              pair_data [2];
  logic [`FLASH_ADDR_W-1:0] pair_pad  [2];

  int          checks;
  int          value_errs;
  int          proto_errs;
  int          cycle_cnt;
  int          cycle_limit;
  int          row;

  flash_subsys dut_i (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .wba_dat_i    (wba_dat_i),
    .wba_dat_o    (wba_dat_o),
    .wba_adr_i    (wba_adr_i),
    .wba_we_i     (wba_we_i),
    .wba_tga_i    (wba_tga_i),
    .wba_stb_i    (wba_stb_i),
    .wba_cyc_i    (wba_cyc_i),
    .wba_ack_o    (wba_ack_o),
    .wbb_dat_i    (wbb_dat_i),
    .wbb_dat_o    (wbb_dat_o),
    .wbb_adr_i    (wbb_adr_i),
    .wbb_we_i     (wbb_we_i),
    .wbb_tga_i    (wbb_tga_i),
    .wbb_stb_i    (wbb_stb_i),
    .wbb_cyc_i    (wbb_cyc_i),
    .wbb_ack_o    (wbb_ack_o),
    .flash_addr_o (flash_addr_o),
    .flash_data_i (flash_data),
    .flash_we_n_o (flash_we_n_o),
    .flash_ce_o   (flash_ce_o)
  );

  flash_model flash (
    .flash_addr_i (flash_addr_o),
    .flash_ce_i   (flash_ce_o),
    .flash_we_n_i (flash_we_n_o),
    .flash_data_o (flash_data)
  );

  // 20 ns clock
  initial begin
    wb_clk_i = 1'b0;
    forever begin
      #10 wb_clk_i = ~wb_clk_i;
    end
  end

  task automatic add_row(input string name, input bit port, input int op, input bit tga,
                         input logic [15:0] adr, input logic [15:0] wdat, input bit both);
    t_name.push_back(name);
    t_port.push_back(port);
    t_op.push_back(op);
    t_tga.push_back(tga);
    t_adr.push_back(adr);
    t_wdat.push_back(wdat);
    t_both.push_back(both);
  endtask

  // both flag pairs a row with the next one, other port
  task automatic build_table();
    add_row("a_page_rst",  PA, OP_READ,  1'b1, 16'h0034, 16'h0000, 1'b0);
    add_row("b_page_rst",  PB, OP_READ,  1'b1, 16'h00c1, 16'h0000, 1'b0);
    add_row("a_direct",    PA, OP_READ,  1'b0, 16'h1234, 16'h0000, 1'b0);
    add_row("b_direct",    PB, OP_READ,  1'b0, 16'hbeef, 16'h0000, 1'b0);
    add_row("a_dir_rnd",   PA, OP_READ,  1'b0, 16'($urandom), 16'h0000, 1'b0);
    add_row("b_dir_rnd",   PB, OP_READ,  1'b0, 16'($urandom), 16'h0000, 1'b0);
    add_row("a_base_wr",   PA, OP_BASE,  1'b1, 16'h0000, 16'h0a5c, 1'b0);
    add_row("a_page_rd",   PA, OP_READ,  1'b1, 16'h0012, 16'h0000, 1'b0);
    add_row("a_page_rnd",  PA, OP_READ,  1'b1, 16'($urandom), 16'h0000, 1'b0);
    add_row("b_page_keep", PB, OP_READ,  1'b1, 16'h0012, 16'h0000, 1'b0);
    add_row("b_base_wr",   PB, OP_BASE,  1'b1, 16'h0000, 16'h03e7, 1'b0);
    add_row("b_page_rd",   PB, OP_READ,  1'b1, 16'h00ff, 16'h0000, 1'b0);
    add_row("a_page_keep", PA, OP_READ,  1'b1, 16'h0012, 16'h0000, 1'b0);
    add_row("tie1_a",      PA, OP_READ,  1'b0, 16'h2222, 16'h0000, 1'b1);
    add_row("tie1_b",      PB, OP_READ,  1'b0, 16'h3333, 16'h0000, 1'b0);
    add_row("tie2_a",      PA, OP_READ,  1'b1, 16'($urandom), 16'h0000, 1'b1);
    add_row("tie2_b",      PB, OP_READ,  1'b1, 16'($urandom), 16'h0000, 1'b0);
    add_row("a_plain_wr",  PA, OP_PLAIN, 1'b0, 16'h1234, 16'hffff, 1'b0);
    add_row("b_plain_wr",  PB, OP_PLAIN, 1'b0, 16'h0012, 16'h0fff, 1'b0);
    add_row("a_dir_after", PA, OP_READ,  1'b0, 16'h1234, 16'h0000, 1'b0);
    add_row("a_pg_after",  PA, OP_READ,  1'b1, 16'h0012, 16'h0000, 1'b0);
    add_row("b_pg_after",  PB, OP_READ,  1'b1, 16'h0012, 16'h0000, 1'b0);
    add_row("tie3_a",      PA, OP_READ,  1'b0, 16'hbeef, 16'h0000, 1'b1);
    add_row("tie3_b",      PB, OP_READ,  1'b0, 16'h1234, 16'h0000, 1'b0);
  endtask

  // direct is five zero bits then the word address
  // paged is a one bit, the base, then the low offset
  function automatic logic [`FLASH_ADDR_W-1:0] expect_addr(input bit port, input bit tga,
                                                           input logic [15:0] adr);
    if (tga) begin
      return {1'b1, base_sh[port], adr[`FLASH_PAGE_W-1:0]};
    end
    return {5'b00000, adr};
  endfunction

  function automatic logic port_ack(input bit port);
    return (port == PB) ? wbb_ack_o : wba_ack_o;
  endfunction

  function automatic logic [15:0] port_data(input bit port);
    return (port == PB) ? wbb_dat_o : wba_dat_o;
  endfunction

  task automatic drive_row(input int idx);
    logic we;
    we = (t_op[idx] != OP_READ);
    if (t_port[idx] == PB) begin
      wbb_we_i  = we;
      wbb_tga_i = t_tga[idx];
      wbb_adr_i = t_adr[idx];
      wbb_dat_i = t_wdat[idx];
      wbb_cyc_i = 1'b1;
      wbb_stb_i = 1'b1;
    end else begin
      wba_we_i  = we;
      wba_tga_i = t_tga[idx];
      wba_adr_i = t_adr[idx];
      wba_dat_i = t_wdat[idx];
      wba_cyc_i = 1'b1;
      wba_stb_i = 1'b1;
    end
  endtask

  task automatic release_port(input bit port);
    if (port == PB) begin
      wbb_cyc_i = 1'b0;
      wbb_stb_i = 1'b0;
      wbb_we_i  = 1'b0;
      wbb_tga_i = 1'b0;
      wbb_adr_i = 16'h0000;
      wbb_dat_i = 16'h0000;
    end else begin
      wba_cyc_i = 1'b0;
      wba_stb_i = 1'b0;
      wba_we_i  = 1'b0;
      wba_tga_i = 1'b0;
      wba_adr_i = 16'h0000;
      wba_dat_i = 16'h0000;
    end
  endtask

  // compare one acked cycle, and track base writes
  task automatic check_response(input int idx, input logic [15:0] data,
                                input logic [`FLASH_ADDR_W-1:0] pad, input int cycles,
                                input bit timed);
    logic [`FLASH_ADDR_W-1:0] exp_pad;
    logic [15:0]              exp_data;
    logic [15:0]              wdat;
    int                       exp_cyc;
    checks = checks + 1;
    wdat   = t_wdat[idx];
    if (flash_we_n_o !== 1'b1) begin
      value_errs = value_errs + 1;
      $display("** Error %s: write enable expected 1, actual %b", t_name[idx], flash_we_n_o);
    end
    if (t_op[idx] == OP_READ) begin
      exp_pad  = expect_addr(t_port[idx], t_tga[idx], t_adr[idx]);
      exp_data = exp_pad[15:0] ^ 16'h5a5a;
      exp_cyc  = 1 + RW;
      if (pad !== exp_pad) begin
        value_errs = value_errs + 1;
        $display("** Error %s: pad address expected %h, actual %h", t_name[idx], exp_pad, pad);
      end
      if (data !== exp_data) begin
        value_errs = value_errs + 1;
        $display("** Error %s: read data expected %h, actual %h", t_name[idx], exp_data, data);
      end
    end else begin
      exp_cyc = 1;
      if (t_op[idx] == OP_BASE) begin
        base_sh[t_port[idx]] = wdat[`FLASH_BASE_W-1:0];
      end
    end
    if (timed && cycles != exp_cyc) begin
      value_errs = value_errs + 1;
      $display("** Error %s: ack latency expected %0d, actual %0d", t_name[idx], exp_cyc, cycles);
    end
  endtask

  // one cycle with no stb, ack and chip enable must be gone
  task automatic idle_cycle(input string name);
    @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    if (wba_ack_o !== 1'b0 || wbb_ack_o !== 1'b0 || flash_ce_o !== 1'b0) begin
      proto_errs = proto_errs + 1;
      $display("ack or chip enable still high one cycle after %s ended", name);
    end
  endtask

  task automatic run_single(input int idx);
    int  cycles;
    bit  got;
    bit  port;
    port   = t_port[idx];
    cycles = 0;
    got    = 1'b0;
    drive_row(idx);
    while (!got && cycles < ROW_CYCLES) begin
      @(posedge wb_clk_i);
      cycles = cycles + 1;
      @(negedge wb_clk_i);
      got = port_ack(port);
    end
    if (!got) begin
      proto_errs = proto_errs + 1;
      $display("no ack for %s within %0d cycles", t_name[idx], ROW_CYCLES);
      release_port(port);
    end else begin
      check_response(idx, port_data(port), flash_addr_o, cycles, 1'b1);
      release_port(port);
    end
    if (t_op[idx] == OP_READ) begin
      last_b_sh = port;
    end
    idle_cycle(t_name[idx]);
  endtask

  task automatic poll_port(input bit p, input int cycles);
    if (!pair_done[p] && port_ack(p)) begin
      pair_done[p] = 1'b1;
      pair_cyc[p]  = cycles;
      pair_data[p] = port_data(p);
      pair_pad[p]  = flash_addr_o;
      release_port(p);
    end else if (pair_done[p] && port_ack(p)) begin
      proto_errs = proto_errs + 1;
      $display("port %0d ack held past one cycle", p);
    end
  endtask

  // two reads launched on the same falling edge
  task automatic run_pair(input int i, input int j);
    int  cycles;
    int  row_of [2];
    bit  exp_first;
    bit  act_first;
    cycles       = 0;
    pair_done[0] = 1'b0;
    pair_done[1] = 1'b0;
    row_of[t_port[i]] = i;
    row_of[t_port[j]] = j;
    // tie goes to the port not granted last
    exp_first = ~last_b_sh;
    drive_row(i);
    drive_row(j);
    while (!(pair_done[0] && pair_done[1]) && cycles < 2 * ROW_CYCLES) begin
      @(posedge wb_clk_i);
      cycles = cycles + 1;
      @(negedge wb_clk_i);
      poll_port(1'b0, cycles);
      poll_port(1'b1, cycles);
    end
    if (!(pair_done[0] && pair_done[1])) begin
      proto_errs = proto_errs + 1;
      $display("no ack for tied pair %s within %0d cycles", t_name[i], 2 * ROW_CYCLES);
      release_port(PA);
      release_port(PB);
    end else if (pair_cyc[0] == pair_cyc[1]) begin
      proto_errs = proto_errs + 1;
      $display("both ports acked in the same cycle in %s", t_name[i]);
    end else begin
      checks    = checks + 1;
      act_first = (pair_cyc[1] < pair_cyc[0]);
      if (act_first != exp_first) begin
        value_errs = value_errs + 1;
        $display("** Error %s: first acked port expected %0d, actual %0d", t_name[i],
                 exp_first, act_first);
      end
      check_response(row_of[0], pair_data[0], pair_pad[0], pair_cyc[0], 1'b0);
      check_response(row_of[1], pair_data[1], pair_pad[1], pair_cyc[1], 1'b0);
    end
    // loser holds the last grant
    last_b_sh = ~exp_first;
    idle_cycle(t_name[i]);
  endtask

  // watchdog on the whole run
  initial begin
    cycle_cnt = 0;
    @(posedge wb_clk_i);
    while (cycle_cnt < cycle_limit) begin
      @(posedge wb_clk_i);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(32'h53d6));
    checks     = 0;
    value_errs = 0;
    proto_errs = 0;
    reset_i    = 1'b1;
    release_port(PA);
    release_port(PB);
    base_sh[0] = '0;
    base_sh[1] = '0;
    last_b_sh  = 1'b1;
    build_table();
    cycle_limit = t_name.size() * ROW_CYCLES + 20;
    repeat (5) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    reset_i = 1'b0;
    // nothing pending straight out of reset
    checks = checks + 1;
    if (wba_ack_o !== 1'b0 || wbb_ack_o !== 1'b0 || flash_ce_o !== 1'b0) begin
      proto_errs = proto_errs + 1;
      $display("ack or chip enable high after reset");
    end
    row = 0;
    while (row < t_name.size()) begin
      if (t_both[row]) begin
        run_pair(row, row + 1);
        row = row + 2;
      end else begin
        run_single(row);
        row = row + 1;
      end
    end
    $display("checks %0d, value errors %0d, handshake errors %0d", checks, value_errs,
             proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== flash_subsys.f ====
+incdir+include
source/flash_pkg.sv
source/flash_window.sv
source/flash_pad_arbiter.sv
source/flash_subsys.sv
bench/flash_model.sv
bench/tb_flash_subsys.sv

// ==== include/flash_defs.svh ====
/*
 * flash subsystem geometry and timing macros
 * address width, read wait count, page layout
 */

`ifndef FLASH_DEFS_SVH
`define FLASH_DEFS_SVH

// flash word address width, 2M words of 16 bits
`define FLASH_ADDR_W 21

// wait cycles from first grant to ack
// must be at least 1
`define FLASH_READ_WAIT 2

// in-page word offset width, 256 words per page
`define FLASH_PAGE_W 8

// page base register width
// msb + base + offset fills the flash address
`define FLASH_BASE_W 12

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run the flash subsystem testbench with verilator
# exits non-zero when the build, the run or the log shows a failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -j 0 \
  --top-module tb_flash_subsys \
  -Mdir "$OBJ" -o tb_flash_subsys \
  -f flash_subsys.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/tb_flash_subsys" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -F -q "*** TEST FAILED ***" "$LOG"; then
  echo "failure reported in $LOG"
  exit 1
fi

echo "no failure reported in $LOG"
exit 0

// ==== source/flash_pad_arbiter.sv ====
/*
 * flash_pad_arbiter: shares one set of flash pads between two windows
 * round-robin grant FSM, registered pad address,
 * chip enable and tied-off write enable
 */

`timescale 1ns/1ps

module flash_pad_arbiter (
  input  logic                   wb_clk_i,
  input  logic                   reset_i,
  // window requests and addresses
  input  logic                   req_a_i,
  input  logic                   req_b_i,
  input  flash_pkg::flash_addr_t addr_a_i,
  input  flash_pkg::flash_addr_t addr_b_i,
  // grants back to the windows
  output logic                   gnt_a_o,
  output logic                   gnt_b_o,
  // flash pads
  output flash_pkg::flash_addr_t flash_addr_o,
  output logic                   flash_ce_o,
  output logic                   flash_we_n_o
);

  flash_pkg::arb_state_t state_q;
  flash_pkg::arb_state_t state_d;

  // set when port b took the last grant
  // reset value leaves port a favored on the first tie
  logic last_b_q;

  // a grant starts on this edge
  logic new_grant;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      flash_pkg::idle: begin
        if (req_a_i && req_b_i) begin
          // tie goes to the port that lost last time
          state_d = last_b_q ? flash_pkg::grant_a : flash_pkg::grant_b;
        end else if (req_a_i) begin
          state_d = flash_pkg::grant_a;
        end else if (req_b_i) begin
          state_d = flash_pkg::grant_b;
        end
      end
      flash_pkg::grant_a: begin
        // held until the window drops req
        // always back through idle, even if b waits
        if (!req_a_i) begin
          state_d = flash_pkg::idle;
        end
      end
      flash_pkg::grant_b: begin
        if (!req_b_i) begin
          state_d = flash_pkg::idle;
        end
      end
      default: begin
        state_d = flash_pkg::idle;
      end
    endcase
  end

  assign new_grant = (state_q == flash_pkg::idle) && (state_d != flash_pkg::idle);

  // state and round-robin pointer
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q  <= flash_pkg::idle;
      last_b_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if (new_grant) begin
        last_b_q <= (state_d == flash_pkg::grant_b);
      end
    end
  end

  // pad address follows the granted window
  // loaded on the grant edge, so it is on the pads with gnt
  always_ff @(posedge wb_clk_i) begin
    if (state_d == flash_pkg::grant_b) begin
      flash_addr_o <= addr_b_i;
    end else if (state_d == flash_pkg::grant_a) begin
      flash_addr_o <= addr_a_i;
    end
  end

  // grants straight from the state register
  assign gnt_a_o = (state_q == flash_pkg::grant_a);
  assign gnt_b_o = (state_q == flash_pkg::grant_b);

  // chip enabled for the whole of any grant
  assign flash_ce_o = (state_q != flash_pkg::idle);

  // no program or erase, write enable never asserted
  assign flash_we_n_o = 1'b1;

endmodule

// ==== source/flash_pkg.sv ====
/*
 * shared types for the flash read subsystem
 * vector typedefs and the pad arbiter state enum
 */

`include "flash_defs.svh"

package flash_pkg;

  // flash word address on the pads
  typedef logic [`FLASH_ADDR_W-1:0] flash_addr_t;

  // wishbone and flash data word
  typedef logic [15:0] wb_data_t;

  // wishbone word address, byte bit 0 not present
  typedef logic [16:1] wb_addr_t;

  // paged window base, selects a page in the upper half
  typedef logic [`FLASH_BASE_W-1:0] page_base_t;

  // pad arbiter states
  typedef enum logic [1:0] {
    idle    = 2'd0,
    grant_a = 2'd1,
    grant_b = 2'd2
  } arb_state_t;

endpackage

// ==== source/flash_subsys.sv ====
/*
 * flash_subsys: dual-port flash read subsystem top
 * window a for the cpu port, window b for boot or dma,
 * pad arbiter onto the single flash chip
 */

`timescale 1ns/1ps

module flash_subsys (
  input  logic                   wb_clk_i,
  input  logic                   reset_i,
  // port a, cpu memory port
  input  flash_pkg::wb_data_t    wba_dat_i,
  output flash_pkg::wb_data_t    wba_dat_o,
  input  flash_pkg::wb_addr_t    wba_adr_i,
  input  logic                   wba_we_i,
  input  logic                   wba_tga_i,
  input  logic                   wba_stb_i,
  input  logic                   wba_cyc_i,
  output logic                   wba_ack_o,
  // port b, boot or dma port
  input  flash_pkg::wb_data_t    wbb_dat_i,
  output flash_pkg::wb_data_t    wbb_dat_o,
  input  flash_pkg::wb_addr_t    wbb_adr_i,
  input  logic                   wbb_we_i,
  input  logic                   wbb_tga_i,
  input  logic                   wbb_stb_i,
  input  logic                   wbb_cyc_i,
  output logic                   wbb_ack_o,
  // flash pads
  output flash_pkg::flash_addr_t flash_addr_o,
  input  flash_pkg::wb_data_t    flash_data_i,
  output logic                   flash_we_n_o,
  output logic                   flash_ce_o
);

  // window to arbiter handshake
  logic                   req_a;
  logic                   req_b;
  logic                   gnt_a;
  logic                   gnt_b;
  flash_pkg::flash_addr_t addr_a;
  flash_pkg::flash_addr_t addr_b;

  flash_window win_a (
    .wb_clk_i  (wb_clk_i),
    .reset_i   (reset_i),
    .wb_dat_i  (wba_dat_i),
    .wb_dat_o  (wba_dat_o),
    .wb_adr_i  (wba_adr_i),
    .wb_we_i   (wba_we_i),
    .wb_tga_i  (wba_tga_i),
    .wb_stb_i  (wba_stb_i),
    .wb_cyc_i  (wba_cyc_i),
    .wb_ack_o  (wba_ack_o),
    .req_o     (req_a),
    .addr_o    (addr_a),
    .gnt_i     (gnt_a),
    .rd_data_i (flash_data_i)
  );

  flash_window win_b (
    .wb_clk_i  (wb_clk_i),
    .reset_i   (reset_i),
    .wb_dat_i  (wbb_dat_i),
    .wb_dat_o  (wbb_dat_o),
    .wb_adr_i  (wbb_adr_i),
    .wb_we_i   (wbb_we_i),
    .wb_tga_i  (wbb_tga_i),
    .wb_stb_i  (wbb_stb_i),
    .wb_cyc_i  (wbb_cyc_i),
    .wb_ack_o  (wbb_ack_o),
    .req_o     (req_b),
    .addr_o    (addr_b),
    .gnt_i     (gnt_b),
    .rd_data_i (flash_data_i)
  );

  // data pad fans out to both windows, only the granted one acks
  flash_pad_arbiter arb (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .req_a_i      (req_a),
    .req_b_i      (req_b),
    .addr_a_i     (addr_a),
    .addr_b_i     (addr_b),
    .gnt_a_o      (gnt_a),
    .gnt_b_o      (gnt_b),
    .flash_addr_o (flash_addr_o),
    .flash_ce_o   (flash_ce_o),
    .flash_we_n_o (flash_we_n_o)
  );

endmodule

// ==== source/flash_window.sv ====
/*
 * flash_window: one wishbone classic slave port onto the flash
 * direct and paged address decode, page base register,
 * pad request and shift-register read wait timer
 */

`timescale 1ns/1ps

`include "flash_defs.svh"

module flash_window #(
  parameter int READ_WAIT = `FLASH_READ_WAIT
) (
  input  logic                   wb_clk_i,
  input  logic                   reset_i,
  // wishbone slave side
  input  flash_pkg::wb_data_t    wb_dat_i,
  output flash_pkg::wb_data_t    wb_dat_o,
  input  flash_pkg::wb_addr_t    wb_adr_i,
  input  logic                   wb_we_i,
  input  logic                   wb_tga_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_cyc_i,
  output logic                   wb_ack_o,
  // pad arbiter side
  output logic                   req_o,
  output flash_pkg::flash_addr_t addr_o,
  input  logic                   gnt_i,
  input  flash_pkg::wb_data_t    rd_data_i
);

  // bus cycle qualifiers
  logic op;
  logic rd_op;
  logic wr_op;
  logic base_op;

  // wait timer, one hot bit walks up to the ack position
  logic [READ_WAIT-1:0] wait_q;
  logic                 wait_start;
  logic                 rd_ack;

  // one cycle ack for writes of either kind
  logic wr_ack_q;

  // page base register
  flash_pkg::page_base_t base_q;

  // candidate flash addresses
  flash_pkg::flash_addr_t addr_direct;
  flash_pkg::flash_addr_t addr_paged;

  // active cycle while both cyc and stb high
  assign op      = wb_cyc_i & wb_stb_i;
  assign rd_op   = op & ~wb_we_i;
  assign wr_op   = op & wb_we_i;
  // tga on a write selects the base register
  // skip the ack cycle so a held stb loads once
  assign base_op = wr_op & wb_tga_i & ~wr_ack_q;

  // direct window, word address zero extended
  assign addr_direct = flash_pkg::flash_addr_t'(wb_adr_i);

  // paged window in the upper half of the flash
  // msb set, then base, then low offset bits
  assign addr_paged = {1'b1, base_q, wb_adr_i[`FLASH_PAGE_W:1]};

  // stays put while the master holds its signals
  assign addr_o = wb_tga_i ? addr_paged : addr_direct;

  // read completes when the walking bit reaches the top
  assign rd_ack = wait_q[READ_WAIT-1];

  // pending read asks for the pads until acked
  assign req_o = rd_op & ~rd_ack;

  // first grant cycle, timer still empty
  assign wait_start = rd_op & gnt_i & ~(|wait_q);

  // read wait timer
  // top bit shifts out after the ack cycle, so it clears itself
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      wait_q <= '0;
    end else if (!rd_op) begin
      // master gave up the cycle
      wait_q <= '0;
    end else begin
      wait_q <= (wait_q << 1) | READ_WAIT'(wait_start);
    end
  end

  // writes acked on the following cycle
  // plain writes go nowhere, flash is read only here
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      wr_ack_q <= 1'b0;
    end else begin
      wr_ack_q <= wr_op & ~wr_ack_q;
    end
  end

  // page base load from the low data bits
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      base_q <= '0;
    end else if (base_op) begin
      base_q <= wb_dat_i[`FLASH_BASE_W-1:0];
    end
  end

  // both ack sources are registered
  assign wb_ack_o = rd_ack | wr_ack_q;

  // shared data pad, valid on the ack cycle of a read
  assign wb_dat_o = rd_data_i;

endmodule
